// ==== include/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word
`define MIPS_DATA_W 32

// 32 architectural registers
`define MIPS_REG_AW 5

// instruction memory, in words
`define MIPS_IMEM_AW 6

// data memory, in words
`define MIPS_DMEM_AW 6

`endif

// ==== verilog/mipsPkg.sv ====
`include "mips_params.svh"

package mipsPkg;

    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} aluOp_e;

    typedef enum logic [1:0] {REGFILE, FROM_MEM, FROM_WB} fwdSel_e;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} coreState_e;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   mem2Reg;
        logic   aluSrcImm;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_DATA_W-1:0] pc;
        logic [`MIPS_DATA_W-1:0] instr;
    } ifId_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_DATA_W-1:0] opA;
        logic [`MIPS_DATA_W-1:0] opB;
        logic [`MIPS_DATA_W-1:0] imm;
    } idEx_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_DATA_W-1:0] aluRes;
        logic [`MIPS_DATA_W-1:0] storeData;
    } exMem_t;

    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic                    mem2Reg;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_DATA_W-1:0] loadData;
        logic [`MIPS_DATA_W-1:0] aluRes;
    } memWb_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_DATA_W-1:0] data;
    } wbCommit_t;

    typedef struct packed {
        logic                     valid;
        logic [`MIPS_DMEM_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0]  data;
    } memWrite_t;

    // writeback mux, shared by decode, execute and memory
    function automatic logic [`MIPS_DATA_W-1:0] wbValue(memWb_t m);
        return m.mem2Reg ? m.loadData : m.aluRes;
    endfunction

endpackage

// ==== verilog/hazardCtrl.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module hazardCtrl
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    i_rstN,
    input  logic                    i_run,
    input  logic                    i_haltSeen,
    input  logic [`MIPS_REG_AW-1:0] i_rs,
    input  logic [`MIPS_REG_AW-1:0] i_rt,
    input  logic                    i_useRs,
    input  logic                    i_useRt,
    input  logic                    i_isBranch,
    input  logic                    i_taken,
    input  idEx_t                   i_idEx,
    input  exMem_t                  i_exMem,
    input  memWb_t                  i_memWb,
    output logic                    o_stall,
    output logic                    o_flush,
    output logic                    o_fetchEn,
    output logic                    o_end,
    output fwdSel_e                 o_fwdA,
    output fwdSel_e                 o_fwdB
);

    coreState_e state;
    logic       loadUse;
    logic       branchWait;
    logic       drained;

    // producer in a later stage writes the register a source needs
    function automatic logic srcHit(logic v, logic wr, logic [`MIPS_REG_AW-1:0] dst,
                                    logic [`MIPS_REG_AW-1:0] src, logic used);
        return v && wr && used && (dst != '0) && (dst == src);
    endfunction

    function automatic fwdSel_e pickFwd(logic [`MIPS_REG_AW-1:0] src);
        if (srcHit(i_exMem.valid, i_exMem.ctrl.regWrite, i_exMem.rd, src, 1'b1))
            return FROM_MEM; // newest value wins
        if (srcHit(i_memWb.valid, i_memWb.regWrite, i_memWb.rd, src, 1'b1))
            return FROM_WB;
        return REGFILE;
    endfunction

    assign loadUse = srcHit(i_idEx.valid, i_idEx.ctrl.memRead, i_idEx.rd, i_rs, i_useRs)
                  || srcHit(i_idEx.valid, i_idEx.ctrl.memRead, i_idEx.rd, i_rt, i_useRt);

    // beq compares in decode, so wait until the operand reaches writeback
    assign branchWait = i_isBranch && (
        srcHit(i_idEx.valid, i_idEx.ctrl.regWrite, i_idEx.rd, i_rs, i_useRs) ||
        srcHit(i_idEx.valid, i_idEx.ctrl.regWrite, i_idEx.rd, i_rt, i_useRt) ||
        srcHit(i_exMem.valid, i_exMem.ctrl.regWrite, i_exMem.rd, i_rs, i_useRs) ||
        srcHit(i_exMem.valid, i_exMem.ctrl.regWrite, i_exMem.rd, i_rt, i_useRt));

    assign o_stall   = loadUse || branchWait;
    assign o_flush   = i_taken || i_haltSeen; // drop the slot behind a redirect or halt
    assign o_fetchEn = (state == RUN);
    assign o_end     = (state == DONE);

    always_comb begin
        o_fwdA = pickFwd(i_idEx.rs);
        o_fwdB = pickFwd(i_idEx.rt);
    end

    assign drained = !i_idEx.valid && !i_exMem.valid && !i_memWb.valid;

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (i_run) state <= RUN;
                RUN:     if (i_haltSeen) state <= DRAIN;
                DRAIN:   if (drained) state <= DONE; // halt has left writeback
                default: state <= DONE;
            endcase
        end
    end

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module fetchStage
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic                     i_rstN,
    input  logic                     i_imemWe,
    input  logic [`MIPS_IMEM_AW-1:0] i_imemAddr,
    input  logic [`MIPS_DATA_W-1:0]  i_imemData,
    input  logic                     i_fetchEn,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  logic                     i_taken,
    input  logic [`MIPS_DATA_W-1:0]  i_target,
    output ifId_t                    o_ifId
);

    logic [`MIPS_DATA_W-1:0] imem [1 << `MIPS_IMEM_AW];
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] instr;

    assign instr = imem[pc[`MIPS_IMEM_AW+1:2]]; // word addressed

    // program load port, only while the core is not fetching
    always_ff @(posedge clk) begin
        if (i_imemWe && !i_fetchEn)
            imem[i_imemAddr] <= i_imemData;
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            pc     <= '0;
            o_ifId <= '0;
        end else if (!i_stall) begin
            if (i_taken)
                pc <= i_target;
            else if (i_fetchEn)
                pc <= pc + `MIPS_DATA_W'(4);
            o_ifId.valid <= i_fetchEn && !i_flush;
            o_ifId.pc    <= pc;
            o_ifId.instr <= instr;
        end
    end

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module decodeStage
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    i_rstN,
    input  ifId_t                   i_ifId,
    input  memWb_t                  i_memWb,
    input  logic                    i_stall,
    output idEx_t                   o_idEx,
    output logic [`MIPS_REG_AW-1:0] o_rs,
    output logic [`MIPS_REG_AW-1:0] o_rt,
    output logic                    o_useRs,
    output logic                    o_useRt,
    output logic                    o_isBranch,
    output logic                    o_taken,
    output logic                    o_haltSeen,
    output logic [`MIPS_DATA_W-1:0] o_target
);

    logic [`MIPS_DATA_W-1:0] regFile [1 << `MIPS_REG_AW];

    opcode_e                 op;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [5:0]              funct;
    logic [`MIPS_DATA_W-1:0] imm;
    logic [`MIPS_DATA_W-1:0] pc4;
    logic [`MIPS_DATA_W-1:0] rsVal;
    logic [`MIPS_DATA_W-1:0] rtVal;
    logic [`MIPS_DATA_W-1:0] wbData;
    logic                    wbEn;
    ctrl_t                   ctrl;
    logic [`MIPS_REG_AW-1:0] dest;
    logic                    useRs;
    logic                    useRt;
    logic                    isBranch;
    logic                    isJump;
    logic                    isHalt;

    assign op    = opcode_e'(i_ifId.instr[31:26]);
    assign o_rs  = i_ifId.instr[25:21];
    assign o_rt  = i_ifId.instr[20:16];
    assign rd    = i_ifId.instr[15:11];
    assign funct = i_ifId.instr[5:0];
    assign imm   = {{(`MIPS_DATA_W-16){i_ifId.instr[15]}}, i_ifId.instr[15:0]};
    assign pc4   = i_ifId.pc + `MIPS_DATA_W'(4);

    // register file, written from writeback and visible in the same cycle
    assign wbData = wbValue(i_memWb);
    assign wbEn   = i_memWb.valid && i_memWb.regWrite && (i_memWb.rd != '0);

    always_ff @(posedge clk) begin
        if (wbEn)
            regFile[i_memWb.rd] <= wbData;
    end

    assign rsVal = (o_rs == '0) ? '0 : (wbEn && i_memWb.rd == o_rs) ? wbData : regFile[o_rs];
    assign rtVal = (o_rt == '0) ? '0 : (wbEn && i_memWb.rd == o_rt) ? wbData : regFile[o_rt];

    always_comb begin
        ctrl     = '0;
        dest     = rd;
        useRs    = 1'b0;
        useRt    = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isHalt   = 1'b0;
        case (op)
            RTYPE: begin
                ctrl.regWrite = 1'b1;
                useRs         = 1'b1;
                useRt         = 1'b1;
                case (funct)
                    6'h20:   ctrl.aluOp = ADD;
                    6'h22:   ctrl.aluOp = SUB;
                    6'h24:   ctrl.aluOp = AND;
                    6'h25:   ctrl.aluOp = OR;
                    6'h2a:   ctrl.aluOp = SLT;
                    default: ctrl.regWrite = 1'b0; // unknown funct is a nop
                endcase
            end
            ADDI, LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = (op == LW);
                ctrl.mem2Reg   = (op == LW);
                dest           = o_rt;
                useRs          = 1'b1;
            end
            SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                useRs          = 1'b1;
                useRt          = 1'b1;
            end
            BEQ: begin
                isBranch = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
            end
            J:       isJump = 1'b1;
            HALT:    isHalt = 1'b1;
            default: ;
        endcase
    end

    assign o_useRs    = i_ifId.valid && useRs;
    assign o_useRt    = i_ifId.valid && useRt;
    assign o_isBranch = i_ifId.valid && isBranch;
    assign o_haltSeen = i_ifId.valid && isHalt;
    assign o_taken    = i_ifId.valid && !i_stall && (isJump || (isBranch && rsVal == rtVal));
    assign o_target   = isJump ? {pc4[31:28], i_ifId.instr[25:0], 2'b00}
                               : pc4 + {imm[`MIPS_DATA_W-3:0], 2'b00};

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_idEx <= '0;
        end else if (i_stall) begin
            o_idEx <= '0; // bubble
        end else begin
            o_idEx.valid <= i_ifId.valid;
            o_idEx.ctrl  <= i_ifId.valid ? ctrl : '0;
            o_idEx.rs    <= o_rs;
            o_idEx.rt    <= o_rt;
            o_idEx.rd    <= dest;
            o_idEx.opA   <= rsVal;
            o_idEx.opB   <= rtVal;
            o_idEx.imm   <= imm;
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module executeStage
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    i_rstN,
    input  idEx_t   i_idEx,
    input  fwdSel_e i_fwdA,
    input  fwdSel_e i_fwdB,
    input  memWb_t  i_memWb,
    output exMem_t  o_exMem
);

    logic [`MIPS_DATA_W-1:0] wbData;
    logic [`MIPS_DATA_W-1:0] srcA;
    logic [`MIPS_DATA_W-1:0] srcB;
    logic [`MIPS_DATA_W-1:0] aluB;
    logic [`MIPS_DATA_W-1:0] aluRes;

    assign wbData = wbValue(i_memWb);

    always_comb begin
        case (i_fwdA)
            FROM_MEM: srcA = o_exMem.aluRes;
            FROM_WB:  srcA = wbData;
            default:  srcA = i_idEx.opA;
        endcase
        case (i_fwdB)
            FROM_MEM: srcB = o_exMem.aluRes;
            FROM_WB:  srcB = wbData;
            default:  srcB = i_idEx.opB;
        endcase
    end

    assign aluB = i_idEx.ctrl.aluSrcImm ? i_idEx.imm : srcB;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            SUB:     aluRes = srcA - aluB;
            AND:     aluRes = srcA & aluB;
            OR:      aluRes = srcA | aluB;
            SLT:     aluRes = {{(`MIPS_DATA_W-1){1'b0}}, $signed(srcA) < $signed(aluB)};
            default: aluRes = srcA + aluB; // add, also load/store address
        endcase
    end

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_exMem <= '0;
        end else begin
            o_exMem.valid     <= i_idEx.valid;
            o_exMem.ctrl      <= i_idEx.ctrl;
            o_exMem.rd        <= i_idEx.rd;
            o_exMem.aluRes    <= aluRes;
            o_exMem.storeData <= srcB; // forwarded rt
        end
    end

endmodule

// ==== verilog/memoryStage.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module memoryStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      i_rstN,
    input  exMem_t    i_exMem,
    output memWb_t    o_memWb,
    output wbCommit_t o_wb,
    output memWrite_t o_memWr
);

    logic [`MIPS_DATA_W-1:0]  dmem [1 << `MIPS_DMEM_AW];
    logic [`MIPS_DMEM_AW-1:0] addr;
    logic                     store;

    assign addr  = i_exMem.aluRes[`MIPS_DMEM_AW+1:2]; // word address
    assign store = i_exMem.valid && i_exMem.ctrl.memWrite;

    always_ff @(posedge clk) begin
        if (store)
            dmem[addr] <= i_exMem.storeData;
    end

    assign o_memWr.valid = store;
    assign o_memWr.addr  = addr;
    assign o_memWr.data  = i_exMem.storeData;

    always_ff @(posedge clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_memWb <= '0;
        end else begin
            o_memWb.valid    <= i_exMem.valid;
            o_memWb.regWrite <= i_exMem.ctrl.regWrite;
            o_memWb.mem2Reg  <= i_exMem.ctrl.mem2Reg;
            o_memWb.rd       <= i_exMem.rd;
            o_memWb.loadData <= dmem[addr];
            o_memWb.aluRes   <= i_exMem.aluRes;
        end
    end

    // writeback commit, r0 never reported
    assign o_wb.valid = o_memWb.valid && o_memWb.regWrite && (o_memWb.rd != '0);
    assign o_wb.rd    = o_memWb.rd;
    assign o_wb.data  = wbValue(o_memWb);

endmodule

// ==== verilog/mipsCore.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module mipsCore
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic                     i_rstN,
    input  logic                     i_imemWe,
    input  logic [`MIPS_IMEM_AW-1:0] i_imemAddr,
    input  logic [`MIPS_DATA_W-1:0]  i_imemData,
    input  logic                     i_run,
    output wbCommit_t                o_wb,
    output memWrite_t                o_memWr,
    output logic                     o_end
);

    ifId_t   ifId;
    idEx_t   idEx;
    exMem_t  exMem;
    memWb_t  memWb;
    fwdSel_e fwdA;
    fwdSel_e fwdB;
    logic    stall;
    logic    flush;
    logic    fetchEn;
    logic    taken;
    logic    isBranch;
    logic    haltSeen;
    logic    useRs;
    logic    useRt;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_DATA_W-1:0] target;

    hazardCtrl hazard0 (
        .clk(clk), .i_rstN(i_rstN), .i_run(i_run), .i_haltSeen(haltSeen),
        .i_rs(rs), .i_rt(rt), .i_useRs(useRs), .i_useRt(useRt),
        .i_isBranch(isBranch), .i_taken(taken), .i_idEx(idEx), .i_exMem(exMem),
        .i_memWb(memWb), .o_stall(stall), .o_flush(flush), .o_fetchEn(fetchEn),
        .o_end(o_end), .o_fwdA(fwdA), .o_fwdB(fwdB)
    );

    fetchStage fetch0 (
        .clk(clk), .i_rstN(i_rstN), .i_imemWe(i_imemWe), .i_imemAddr(i_imemAddr),
        .i_imemData(i_imemData), .i_fetchEn(fetchEn), .i_stall(stall),
        .i_flush(flush), .i_taken(taken), .i_target(target), .o_ifId(ifId)
    );

    decodeStage decode0 (
        .clk(clk), .i_rstN(i_rstN), .i_ifId(ifId), .i_memWb(memWb), .i_stall(stall),
        .o_idEx(idEx), .o_rs(rs), .o_rt(rt), .o_useRs(useRs), .o_useRt(useRt),
        .o_isBranch(isBranch), .o_taken(taken), .o_haltSeen(haltSeen), .o_target(target)
    );

    executeStage execute0 (
        .clk(clk), .i_rstN(i_rstN), .i_idEx(idEx), .i_fwdA(fwdA), .i_fwdB(fwdB),
        .i_memWb(memWb), .o_exMem(exMem)
    );

    memoryStage memory0 (
        .clk(clk), .i_rstN(i_rstN), .i_exMem(exMem), .o_memWb(memWb),
        .o_wb(o_wb), .o_memWr(o_memWr)
    );

endmodule

// ==== tb/mipsCore_props.sv ====
`timescale 1ns/100ps

module mipsCore_props
    import mipsPkg::*;
(
    input logic      clk,
    input logic      i_rstN,
    input logic      i_flush,
    input idEx_t     i_idEx,
    input wbCommit_t i_wb,
    input logic      i_end
);

    endSticky: assert property (@(posedge clk) disable iff (!i_rstN) i_end |=> i_end)
        else $error("end flag fell after rising");

    // flushed slot is still a bubble once it reaches decode/execute
    flushIdEx: assert property (@(posedge clk) disable iff (!i_rstN)
                                $past(i_flush, 2) |-> !i_idEx.valid)
        else $error("flushed slot reached decode/execute as valid");

    noR0Commit: assert property (@(posedge clk) disable iff (!i_rstN)
                                 i_wb.valid |-> (i_wb.rd != '0))
        else $error("commit reported for register 0");

endmodule

bind mipsCore mipsCore_props props0 (
    .clk(clk), .i_rstN(i_rstN), .i_flush(flush), .i_idEx(idEx),
    .i_wb(o_wb), .i_end(o_end)
);

// ==== tb/mipsCore_tb.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module mipsCore_tb
    import mipsPkg::*;
();

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [4:0][5:0] aluFuncts = {fnSlt, fnOr, fnAnd, fnSub, fnAdd};
    localparam int progLen = 1 << `MIPS_IMEM_AW;

    logic                     clk;
    logic                     rstN;
    logic                     imemWe;
    logic [`MIPS_IMEM_AW-1:0] imemAddr;
    logic [`MIPS_DATA_W-1:0]  imemData;
    logic                     run;
    wbCommit_t                wb;
    memWrite_t                memWr;
    logic                     coreEnd;

    logic [`MIPS_DATA_W-1:0] prog [progLen];
    wbCommit_t               expWb [$];
    memWrite_t               expSt [$];
    integer                  seed;
    int                      wbTotal;
    int                      wbSeen;
    int                      cyc;

    mipsCore dut0 (
        .clk(clk), .i_rstN(rstN), .i_imemWe(imemWe), .i_imemAddr(imemAddr),
        .i_imemData(imemData), .i_run(run), .o_wb(wb), .o_memWr(memWr), .o_end(coreEnd)
    );

    function automatic logic [31:0] encR(int rd, int rs, int rt, logic [5:0] funct);
        return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic buildProgram();
        int kind;
        int rd;
        int rs;
        int rt;
        prog[0]  = encI(ADDI, 0, 1, 16'd5);
        prog[1]  = encI(ADDI, 0, 2, 16'hfffd); // -3
        prog[2]  = encI(ADDI, 0, 3, 16'h007f);
        prog[3]  = encR(4, 1, 2, fnAdd);       // r2 from wb, r1 via regfile bypass
        prog[4]  = encR(5, 4, 1, fnSub);       // r4 from mem stage
        prog[5]  = encR(6, 2, 1, fnSlt);       // negative vs positive
        prog[6]  = encR(7, 1, 2, fnSlt);
        prog[7]  = encR(8, 3, 5, fnAnd);
        prog[8]  = encR(9, 8, 2, fnOr);
        prog[9]  = encI(SW, 0, 4, 16'd8);
        prog[10] = encI(SW, 0, 9, 16'd12);
        prog[11] = encI(LW, 0, 10, 16'd8);
        prog[12] = encR(11, 10, 1, fnAdd);     // load-use
        prog[13] = encI(SW, 0, 11, 16'd16);
        prog[14] = encI(ADDI, 0, 12, 16'd7);
        prog[15] = encI(BEQ, 12, 11, 16'd1);   // taken, r12 still in flight
        prog[16] = encI(ADDI, 0, 13, 16'd99);  // skipped
        prog[17] = encI(BEQ, 1, 2, 16'd1);     // not taken
        prog[18] = {J, 26'd20};
        prog[19] = encI(ADDI, 0, 14, 16'd55);  // jumped over
        for (int n = 20; n < 44; n++) begin
            kind = $unsigned($random(seed)) % 6;
            rd   = 1 + $unsigned($random(seed)) % 12;
            rs   = 1 + $unsigned($random(seed)) % 12;
            rt   = 1 + $unsigned($random(seed)) % 12;
            if (kind < 5)
                prog[n] = encR(rd, rs, rt, aluFuncts[kind]);
            else
                prog[n] = encI(ADDI, rs, rd, 16'($random(seed)));
        end
        prog[44] = encI(HALT, 0, 0, 16'd0);
        for (int n = 45; n < progLen; n++)
            prog[n] = {HALT, 26'(n)}; // unused words decode as halt
    endtask

    // ISA-level model, no pipeline
    function automatic int runModel();
        logic [31:0] regs [32];
        logic [31:0] mem [1 << `MIPS_DMEM_AW];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        halted;
        int          commits;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        pc      = '0;
        res     = '0;
        commits = 0;
        halted  = 1'b0;
        for (int step = 0; step < 1000 && !halted; step++) begin
            ins = prog[pc[`MIPS_IMEM_AW+1:2]];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea  = a + imm;
            dst = '0;
            pc  = pc + 4;
            case (ins[31:26])
                RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnAdd:   res = a + b;
                        fnSub:   res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dst = '0;
                    endcase
                end
                ADDI: begin
                    dst = ins[20:16];
                    res = ea;
                end
                LW: begin
                    dst = ins[20:16];
                    res = mem[ea[`MIPS_DMEM_AW+1:2]];
                end
                SW: begin
                    mem[ea[`MIPS_DMEM_AW+1:2]] = b;
                    expSt.push_back(memWrite_t'{1'b1, ea[`MIPS_DMEM_AW+1:2], b});
                end
                BEQ:     if (a == b) pc = pc + {imm[29:0], 2'b00};
                J:       pc = {pc[31:28], ins[25:0], 2'b00};
                HALT:    halted = 1'b1;
                default: ;
            endcase
            if (dst != '0) begin
                regs[dst] = res;
                expWb.push_back(wbCommit_t'{1'b1, dst, res});
                commits++;
            end
        end
        return commits;
    endfunction

    task automatic checkCommit(input wbCommit_t want, input wbCommit_t got);
        if (got !== want)
            abortRun($sformatf("CHECK FAILED at %0t: o_wb expected r%0d=%h, got r%0d=%h",
                               $time, want.rd, want.data, got.rd, got.data));
    endtask

    task automatic checkStore(input memWrite_t want, input memWrite_t got);
        if (got !== want)
            abortRun($sformatf("CHECK FAILED at %0t: o_memWr expected [%0d]=%h, got [%0d]=%h",
                               $time, want.addr, want.data, got.addr, got.data));
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs settle between edges
    always @(negedge clk) begin
        if (rstN && wb.valid) begin
            if (expWb.size() == 0)
                abortRun($sformatf("unexpected register commit at %0t: r%0d = %h",
                                   $time, wb.rd, wb.data));
            else begin
                checkCommit(expWb.pop_front(), wb);
                wbSeen++;
            end
        end
        if (rstN && memWr.valid) begin
            if (expSt.size() == 0)
                abortRun($sformatf("unexpected store at %0t to word %0d", $time, memWr.addr));
            else
                checkStore(expSt.pop_front(), memWr);
        end
    end

    initial begin
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        run      = 1'b0;
        wbSeen   = 0;
        seed     = 32'h820f;
        buildProgram();
        wbTotal = runModel();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            imemWe   <= 1'b1;
            imemAddr <= i[`MIPS_IMEM_AW-1:0];
            imemData <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
        run    <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        for (cyc = 0; cyc < 5000 && !coreEnd; cyc++)
            @(posedge clk);
        if (!coreEnd)
            abortRun("timed out waiting for the core to raise its end flag");
        repeat (8) begin // quiet window, no late commits
            @(posedge clk);
            if (!coreEnd)
                abortRun("end flag fell after it had risen");
        end
        if (wbSeen != wbTotal || expWb.size() != 0 || expSt.size() != 0)
            abortRun($sformatf("saw %0d commits, model expects %0d; %0d stores missing",
                               wbSeen, wbTotal, expSt.size()));
        else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/mipsPkg.sv
verilog/hazardCtrl.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
tb/mipsCore_props.sv
tb/mipsCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module mipsCore_tb -f sim.f -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log
grep -q "SIMULATION PASSED" sim.log || { echo "run.sh: pass line not found"; exit 1; }
echo "run.sh: pass line found"
